/* source/cachePkg.sv */
`default_nettype none

// geometry of the direct-mapped cache and the address split
// addr = {tag, index, offset}
package cachePkg;

  typedef logic [31:0] addrT; // byte address
  typedef logic [31:0] wordT; // cpu data word

  // 16-byte lines
  localparam int defaultOffsetWidth = 4;
  // 32 lines
  localparam int defaultIndexWidth = 5;

endpackage

`default_nettype wire

/* source/accessPkg.sv */
`default_nettype none

// transactions on the cpu side and on the memory side
package accessPkg;

  // encoding kept from the load/store buffer
  typedef enum logic [1:0] {
    accessNone = 2'b00,
    accessByte = 2'b01,
    accessHalf = 2'b10,
    accessWord = 2'b11
  } accessKindT;

  // held as a level until the response pulse
  typedef struct packed {
    accessKindT     kind;
    logic           write; // 1 = store
    cachePkg::addrT addr;
    cachePkg::wordT data;
  } cpuReqT;

  typedef struct packed {
    logic           valid;
    logic           write;     // 1 = write-back, 0 = refill read
    cachePkg::addrT blockAddr; // offset bits zero
  } memReqT;

  typedef enum logic [1:0] {
    stateIdle,
    stateRespond,
    stateWriteBack,
    stateRefill
  } ctrlStateT;

endpackage

`default_nettype wire

/* source/tagStore.sv */
`default_nettype none

module tagStore #(
  parameter int offsetWidth = 4,
  parameter int indexWidth  = 5
) (
  input  logic           clkIn,
  input  logic           resetIn,
  input  cachePkg::addrT addr,
  input  logic           fill,
  input  logic           markDirty,
  input  logic           markClean,
  output logic           hit,
  output logic           victimDirty,
  output cachePkg::addrT victimBlock
);
  import cachePkg::*;

  localparam int lineCount = 2 ** indexWidth;
  localparam int tagWidth  = $bits(addrT) - indexWidth - offsetWidth;

  typedef logic [indexWidth-1:0] indexT;
  typedef logic [tagWidth-1:0]   tagT;

  logic [lineCount-1:0] validBits;
  logic [lineCount-1:0] dirtyBits;
  tagT                  tagArray [lineCount];

  indexT index;
  tagT   reqTag;
  tagT   storedTag;

  assign index     = addr[offsetWidth +: indexWidth];
  assign reqTag    = addr[$bits(addrT)-1 -: tagWidth];
  assign storedTag = tagArray[index];

  // lookup on the live request address
  assign hit         = validBits[index] && (storedTag == reqTag);
  assign victimDirty = validBits[index] && dirtyBits[index];
  assign victimBlock = {storedTag, index, {offsetWidth{1'b0}}};

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else begin
      if (fill) begin
        validBits[index] <= 1'b1;
        dirtyBits[index] <= 1'b0; // fresh line from memory
      end
      if (markDirty) begin
        dirtyBits[index] <= 1'b1;
      end
      if (markClean) begin
        dirtyBits[index] <= 1'b0; // victim now in memory
      end
    end
  end

  always_ff @(posedge clkIn) begin
    if (fill) begin
      tagArray[index] <= reqTag;
    end
  end

  // controller only stores into a line it has just hit
  validDirtyCheck: assert property (
    @(posedge clkIn) disable iff (resetIn)
    markDirty |-> validBits[index]
  ) else $error("tagStore: markDirty on an invalid line");

endmodule

`default_nettype wire

/* source/lineStore.sv */
`default_nettype none

module lineStore #(
  parameter int offsetWidth = 4,
  parameter int indexWidth  = 5
) (
  input  logic                          clkIn,
  input  cachePkg::addrT                addr,
  input  accessPkg::accessKindT         kind,
  input  cachePkg::wordT                writeData,
  input  logic                          writeHit,
  input  logic                          fill,
  input  logic [8*(2**offsetWidth)-1:0] fillLine,
  output cachePkg::wordT                readWord,
  output logic [8*(2**offsetWidth)-1:0] victimLine
);
  import cachePkg::*;
  import accessPkg::*;

  localparam int lineBits  = 8 * (2 ** offsetWidth);
  localparam int lineCount = 2 ** indexWidth;

  typedef logic [lineBits-1:0]    lineT;
  typedef logic [indexWidth-1:0]  indexT;
  typedef logic [offsetWidth-1:0] offsetT;

  lineT dataArray [lineCount];

  indexT      index;
  offsetT     offset;
  offsetT     wordBase;
  lineT       line;
  lineT       mergedLine;
  wordT       selWord;
  wordT       shiftedData;
  logic [3:0] byteEnable;

  assign index    = addr[offsetWidth +: indexWidth];
  assign offset   = addr[offsetWidth-1:0];
  assign wordBase = offset & ~offsetT'(3); // aligned word holding the access

  assign line       = dataArray[index];
  assign victimLine = line;
  assign selWord    = line[wordBase*8 +: 32];

  // zero-extended lane extract, accesses are naturally aligned
  always_comb begin
    case (kind)
      accessByte: readWord = {24'b0, selWord[offset[1:0]*8 +: 8]};
      accessHalf: readWord = {16'b0, selWord[offset[1]*16 +: 16]};
      default:    readWord = selWord;
    endcase
  end

  always_comb begin
    case (kind)
      accessByte: byteEnable = 4'b0001 << offset[1:0];
      accessHalf: byteEnable = 4'b0011 << offset[1:0];
      accessWord: byteEnable = 4'b1111;
      default:    byteEnable = 4'b0000;
    endcase
  end

  // low bytes of the store data moved up to their lanes
  assign shiftedData = writeData << (offset[1:0] * 8);

  always_comb begin
    mergedLine = line;
    for (int b = 0; b < 4; b++) begin
      if (byteEnable[b]) begin
        mergedLine[wordBase*8 + b*8 +: 8] = shiftedData[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clkIn) begin
    if (fill) begin
      dataArray[index] <= fillLine;
    end else if (writeHit) begin
      dataArray[index] <= mergedLine;
    end
  end

  // a refill and a store hit belong to different controller states
  exclusiveWrite: assert property (
    @(posedge clkIn) !(writeHit && fill)
  ) else $error("lineStore: writeHit and fill in the same cycle");

endmodule

`default_nettype wire

/* source/cacheController.sv */
`default_nettype none

module cacheController #(
  parameter int offsetWidth = 4,
  parameter int indexWidth  = 5
) (
  input  logic                          clkIn,
  input  logic                          resetIn,
  input  accessPkg::cpuReqT             cpuReq,
  input  logic                          hit,
  input  logic                          victimDirty,
  input  cachePkg::addrT                victimBlock,
  input  cachePkg::wordT                readWord,
  input  logic [8*(2**offsetWidth)-1:0] victimLine,
  input  logic                          acceptWrite,
  input  logic                          memDataValid,
  output logic                          fill,
  output logic                          markDirty,
  output logic                          markClean,
  output logic                          writeHit,
  output accessPkg::memReqT             memReq,
  output logic [8*(2**offsetWidth)-1:0] memOut,
  output logic                          dataOutValid,
  output logic                          writeDone,
  output cachePkg::wordT                dataOut
);
  import cachePkg::*;
  import accessPkg::*;

  ctrlStateT state;
  ctrlStateT nextState;

  logic active;
  logic readHit;
  logic misaligned;
  addrT refillBlock;

  // memory request fields, packed into memReq below
  logic memValid;
  logic memWrite;
  addrT memBlock;

  assign active      = cpuReq.kind != accessNone;
  assign readHit     = (state == stateIdle) && active && hit && !cpuReq.write;
  assign refillBlock = {cpuReq.addr[$bits(addrT)-1:offsetWidth], {offsetWidth{1'b0}}};

  always_comb begin
    nextState = state;
    fill      = 1'b0;
    markDirty = 1'b0;
    markClean = 1'b0;
    writeHit  = 1'b0;
    case (state)
      stateIdle: begin
        if (active) begin
          if (hit) begin
            nextState = stateRespond;
            if (cpuReq.write) begin
              writeHit  = 1'b1;
              markDirty = 1'b1;
            end
          end else if (victimDirty) begin
            nextState = stateWriteBack;
          end else begin
            nextState = stateRefill;
          end
        end
      end
      // request is dropping this cycle, do not serve it again
      stateRespond: nextState = stateIdle;
      stateWriteBack: begin
        if (acceptWrite) begin
          markClean = 1'b1;
          nextState = stateRefill;
        end
      end
      stateRefill: begin
        if (memDataValid) begin
          fill      = 1'b1;
          nextState = stateIdle; // lookup again, hits now
        end
      end
      default: nextState = stateIdle;
    endcase
  end

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      state        <= stateIdle;
      memValid     <= 1'b0;
      memWrite     <= 1'b0;
      dataOutValid <= 1'b0;
      writeDone    <= 1'b0;
    end else begin
      state        <= nextState;
      memValid     <= (nextState == stateWriteBack) || (nextState == stateRefill);
      memWrite     <= nextState == stateWriteBack;
      dataOutValid <= readHit;
      writeDone    <= writeHit;
    end
  end

  always_ff @(posedge clkIn) begin
    memBlock <= (nextState == stateWriteBack) ? victimBlock : refillBlock;
    if (readHit) begin
      dataOut <= readWord;
    end
  end

  assign memReq = '{valid: memValid, write: memWrite, blockAddr: memBlock};
  assign memOut = victimLine; // line is untouched until the refill lands

  always_comb begin
    case (cpuReq.kind)
      accessHalf: misaligned = cpuReq.addr[0];
      accessWord: misaligned = cpuReq.addr[1:0] != 2'b00;
      default:    misaligned = 1'b0;
    endcase
  end

  alignedReq: assert property (
    @(posedge clkIn) disable iff (resetIn) !misaligned
  ) else $error("cacheController: misaligned request at %h", cpuReq.addr);

  noMemWhenIdle: assert property (
    @(posedge clkIn) disable iff (resetIn)
    (state == stateIdle || state == stateRespond) |-> !memReq.valid
  ) else $error("cacheController: memReq.valid outside a miss");

  oneResponse: assert property (
    @(posedge clkIn) disable iff (resetIn) !(dataOutValid && writeDone)
  ) else $error("cacheController: dataOutValid and writeDone together");

  // the victim shares its index with the request it makes room for
  victimIndex: assert property (
    @(posedge clkIn) disable iff (resetIn)
    memReq.write |->
      memReq.blockAddr[offsetWidth +: indexWidth] == cpuReq.addr[offsetWidth +: indexWidth]
  ) else $error("cacheController: write-back index differs from request");

endmodule

`default_nettype wire

/* source/dcacheTop.sv */
`default_nettype none

module dcacheTop #(
  parameter int offsetWidth = cachePkg::defaultOffsetWidth,
  parameter int indexWidth  = cachePkg::defaultIndexWidth
) (
  input  logic                          clkIn,
  input  logic                          resetIn,
  input  accessPkg::cpuReqT             cpuReq,
  input  logic                          acceptWrite,
  input  logic                          memDataValid,
  input  logic [8*(2**offsetWidth)-1:0] memDataIn,
  output accessPkg::memReqT             memReq,
  output logic [8*(2**offsetWidth)-1:0] memOut,
  output logic                          dataOutValid,
  output cachePkg::wordT                dataOut,
  output logic                          writeDone
);
  import cachePkg::*;

  localparam int lineBits = 8 * (2 ** offsetWidth);

  logic                hit;
  logic                victimDirty;
  addrT                victimBlock;
  wordT                readWord;
  logic [lineBits-1:0] victimLine;
  logic                fill;
  logic                markDirty;
  logic                markClean;
  logic                writeHit;

  tagStore #(
    .offsetWidth(offsetWidth),
    .indexWidth (indexWidth)
  ) tags (
    .clkIn      (clkIn),
    .resetIn    (resetIn),
    .addr       (cpuReq.addr),
    .fill       (fill),
    .markDirty  (markDirty),
    .markClean  (markClean),
    .hit        (hit),
    .victimDirty(victimDirty),
    .victimBlock(victimBlock)
  );

  lineStore #(
    .offsetWidth(offsetWidth),
    .indexWidth (indexWidth)
  ) lines (
    .clkIn     (clkIn),
    .addr      (cpuReq.addr),
    .kind      (cpuReq.kind),
    .writeData (cpuReq.data),
    .writeHit  (writeHit),
    .fill      (fill),
    .fillLine  (memDataIn),
    .readWord  (readWord),
    .victimLine(victimLine)
  );

  cacheController #(
    .offsetWidth(offsetWidth),
    .indexWidth (indexWidth)
  ) ctrl (
    .clkIn       (clkIn),
    .resetIn     (resetIn),
    .cpuReq      (cpuReq),
    .hit         (hit),
    .victimDirty (victimDirty),
    .victimBlock (victimBlock),
    .readWord    (readWord),
    .victimLine  (victimLine),
    .acceptWrite (acceptWrite),
    .memDataValid(memDataValid),
    .fill        (fill),
    .markDirty   (markDirty),
    .markClean   (markClean),
    .writeHit    (writeHit),
    .memReq      (memReq),
    .memOut      (memOut),
    .dataOutValid(dataOutValid),
    .writeDone   (writeDone),
    .dataOut     (dataOut)
  );

endmodule

`default_nettype wire

/* test/memoryModel.sv */
`default_nettype none

// backing memory, answers each memReq once after 1 to 4 cycles
module memoryModel #(
  parameter int offsetWidth = 4
) (
  input  logic                          clkIn,
  input  logic                          resetIn,
  input  accessPkg::memReqT             memReq,
  input  logic [8*(2**offsetWidth)-1:0] memOut,
  output logic                          acceptWrite,
  output logic                          memDataValid,
  output logic [8*(2**offsetWidth)-1:0] memDataIn
);
  import cachePkg::*;

  localparam int lineBits = 8 * (2 ** offsetWidth);

  typedef logic [lineBits-1:0] lineT;

  lineT storage [addrT]; // shadow copy of every line written back

  function automatic logic [7:0] initByte(addrT a);
    logic [31:0] h;
    h = a * 32'h9e37_79b1;
    return h[31:24] ^ h[7:0];
  endfunction

  function automatic lineT readLine(addrT block);
    lineT l;
    if (storage.exists(block)) begin
      return storage[block];
    end
    for (int i = 0; i < lineBits / 8; i++) begin
      l[i*8 +: 8] = initByte(block + addrT'(i));
    end
    return l;
  endfunction

  initial begin
    int delay;
    acceptWrite  = 1'b0;
    memDataValid = 1'b0;
    memDataIn    = '0;
    forever begin
      @(posedge clkIn);
      #1;
      if (!resetIn && memReq.valid) begin
        delay = $urandom_range(4, 1);
        for (int i = 1; i < delay; i++) begin
          @(posedge clkIn);
          #1;
        end
        if (memReq.write) begin
          storage[memReq.blockAddr] = memOut;
          acceptWrite = 1'b1;
        end else begin
          memDataIn    = readLine(memReq.blockAddr);
          memDataValid = 1'b1;
        end
        @(posedge clkIn);
        #1;
        acceptWrite  = 1'b0; // single-cycle answer
        memDataValid = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* test/dcacheTb.sv */
`default_nettype none

module dcacheTb;
  import cachePkg::*;
  import accessPkg::*;

  localparam int clockPeriod = 40;
  localparam int resetCycles = 16;
  localparam int accessCount = 400;
  localparam int driveDelay  = 1;
  localparam int lineBytes   = 2 ** defaultOffsetWidth;
  localparam int lineBits    = 8 * lineBytes;
  localparam addrT tagChoices [3] = '{32'h0000_0a31, 32'h0001_c4f2, 32'h0007_f0e5};

  logic                clkIn;
  logic                resetIn;
  cpuReqT              cpuReq;
  logic                acceptWrite;
  logic                memDataValid;
  logic [lineBits-1:0] memDataIn;
  memReqT              memReq;
  logic [lineBits-1:0] memOut;
  logic                dataOutValid;
  wordT                dataOut;
  logic                writeDone;

  logic [7:0]          refMem [addrT]; // bytes stored so far
  wordT                expData;
  logic [lineBits-1:0] expLine;
  logic                pending;
  logic                pendingWrite;
  logic                expectHit;
  logic                reqSeen;

  dcacheTop #(
    .offsetWidth(defaultOffsetWidth),
    .indexWidth (defaultIndexWidth)
  ) dut (
    .clkIn(clkIn), .resetIn(resetIn), .cpuReq(cpuReq),
    .acceptWrite(acceptWrite), .memDataValid(memDataValid), .memDataIn(memDataIn),
    .memReq(memReq), .memOut(memOut),
    .dataOutValid(dataOutValid), .dataOut(dataOut), .writeDone(writeDone)
  );

  memoryModel #(.offsetWidth(defaultOffsetWidth)) mem (
    .clkIn(clkIn), .resetIn(resetIn), .memReq(memReq), .memOut(memOut),
    .acceptWrite(acceptWrite), .memDataValid(memDataValid), .memDataIn(memDataIn)
  );

  initial begin
    clkIn = 1'b0;
    forever #(clockPeriod / 2) clkIn = ~clkIn;
  end

  function automatic logic [7:0] initByte(addrT a);
    logic [31:0] h;
    h = a * 32'h9e37_79b1;
    return h[31:24] ^ h[7:0];
  endfunction

  function automatic logic [7:0] refByte(addrT a);
    if (refMem.exists(a)) begin
      return refMem[a];
    end
    return initByte(a);
  endfunction

  function automatic int accessSize(accessKindT kind);
    return (kind == accessByte) ? 1 : (kind == accessHalf) ? 2 : 4;
  endfunction

  task automatic reportFailure();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  // line the write-back should carry
  always @(negedge clkIn) begin
    for (int i = 0; i < lineBytes; i++) begin
      expLine[i*8 +: 8] = refByte(memReq.blockAddr + addrT'(i));
    end
  end

  quietAfterReset: assert property (@(posedge clkIn) disable iff (resetIn)
    !reqSeen |-> !dataOutValid && !writeDone && !memReq.valid && dut.ctrl.state == stateIdle
  ) else begin
    $display("cache became active before the first request");
    reportFailure();
  end

  readDataCheck: assert property (@(posedge clkIn) disable iff (resetIn)
    dataOutValid |-> dataOut == expData
  ) else begin
    $display("error: dataOut = %h, expected %h", $sampled(dataOut), $sampled(expData));
    reportFailure();
  end

  readPulseCheck: assert property (@(posedge clkIn) disable iff (resetIn)
    dataOutValid |-> pending && !pendingWrite
  ) else begin
    $display("dataOutValid pulsed without a read waiting for it");
    reportFailure();
  end

  writePulseCheck: assert property (@(posedge clkIn) disable iff (resetIn)
    writeDone |-> pending && pendingWrite
  ) else begin
    $display("writeDone pulsed without a write waiting for it");
    reportFailure();
  end

  hitLatencyCheck: assert property (@(posedge clkIn) disable iff (resetIn)
    $rose(cpuReq.kind != accessNone) && expectHit |=> dataOutValid || writeDone
  ) else begin
    $display("hit on a just used line did not respond on the next edge");
    reportFailure();
  end

  noRefetchCheck: assert property (@(posedge clkIn) disable iff (resetIn)
    expectHit |-> !memReq.valid
  ) else begin
    $display("memory request raised for a line that was just used");
    reportFailure();
  end

  writeBackCheck: assert property (@(posedge clkIn) disable iff (resetIn)
    memReq.valid && memReq.write |-> memOut == expLine
  ) else begin
    $display("error: memOut = %h, expected %h", $sampled(memOut), $sampled(expLine));
    reportFailure();
  end

  task automatic runAccess(accessKindT kind, logic write, addrT addr, wordT data, logic sameLine);
    int size;
    size = accessSize(kind);
    expData = '0;
    for (int i = 0; i < size; i++) begin
      expData[i*8 +: 8] = refByte(addr + addrT'(i)); // zero-extended
    end
    pending      = 1'b1;
    pendingWrite = write;
    expectHit    = sameLine;
    reqSeen      = 1'b1;
    cpuReq.kind  = kind;
    cpuReq.write = write;
    cpuReq.addr  = addr;
    cpuReq.data  = data;
    do begin
      @(posedge clkIn);
      #driveDelay;
    end while (!(dataOutValid || writeDone));
    cpuReq.kind = accessNone;
    @(posedge clkIn); // pulse checked at this edge
    #driveDelay;
    if (write) begin
      for (int i = 0; i < size; i++) begin
        refMem[addr + addrT'(i)] = data[i*8 +: 8];
      end
    end
    pending   = 1'b0;
    expectHit = 1'b0;
    @(posedge clkIn); // no second pulse may follow
    #driveDelay;
  endtask

  initial begin
    accessKindT kind;
    addrT       addr;
    addrT       lastBlock;
    logic       sameLine;
    void'($urandom(32'hfcb508a5));
    resetIn      = 1'b1;
    cpuReq       = '0;
    pending      = 1'b0;
    pendingWrite = 1'b0;
    expectHit    = 1'b0;
    reqSeen      = 1'b0;
    expData      = '0;
    lastBlock    = '0;
    repeat (resetCycles) @(posedge clkIn);
    #driveDelay;
    resetIn = 1'b0;
    repeat (4) @(posedge clkIn); // idle cycles before the first request
    #driveDelay;
    for (int n = 0; n < accessCount; n++) begin
      kind     = accessKindT'($urandom_range(3, 1));
      sameLine = (n > 0) && ($urandom_range(1, 0) == 1);
      if (sameLine) begin
        addr = lastBlock;
      end else begin
        // few indexes and three tags so lines get evicted often
        addr = (tagChoices[$urandom_range(2, 0)] << (defaultIndexWidth + defaultOffsetWidth))
             | (addrT'($urandom_range(7, 0)) << defaultOffsetWidth);
      end
      addr      = addr | (addrT'($urandom_range(lineBytes - 1, 0))
                          & ~addrT'(accessSize(kind) - 1));
      lastBlock = addr & ~addrT'(lineBytes - 1);
      runAccess(kind, 1'($urandom_range(1, 0)), addr, $urandom(), sameLine);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

  initial begin
    #((resetCycles + accessCount * 40) * clockPeriod);
    $display("timeout: the cache stopped responding before all accesses were done");
    reportFailure();
  end

endmodule

`default_nettype wire

/* Bender.yml */
package:
  name: dcache

sources:
  - source/cachePkg.sv
  - source/accessPkg.sv
  - source/tagStore.sv
  - source/lineStore.sv
  - source/cacheController.sv
  - source/dcacheTop.sv
  - target: test
    files:
      - test/memoryModel.sv
      - test/dcacheTb.sv

/* build.f */
source/cachePkg.sv
source/accessPkg.sv
source/tagStore.sv
source/lineStore.sv
source/cacheController.sv
source/dcacheTop.sv
test/memoryModel.sv
test/dcacheTb.sv
